/* src/druaga_settings.svh */
`ifndef DRUAGA_SETTINGS_SVH
`define DRUAGA_SETTINGS_SVH

// Shared word memory in place of the SDRAM
`define ROM_WORDS     16384
`define MEM_AW        14

// Sound ROM region, download byte 0x4000
`define SND_WORD_BASE 8192

// CPU side byte address widths
`define MAIN_AW       14
`define SND_AW        13

// Download byte address width
`define DL_AW         15

`endif

/* src/druaga_pkg.sv */
`include "druaga_settings.svh"

package druaga_pkg;

	// Board variants sharing this hardware
	typedef enum logic [2:0] {
		druaga_a = 3'd0,
		druaga_b = 3'd1,
		mappy    = 3'd2,
		digdug2  = 3'd3,
		motos    = 3'd4,
		superpac = 3'd5,
		grobda   = 3'd6,
		phozon   = 3'd7
	} game_model_e;

	typedef logic [15:0] mem_word_t;
	typedef logic [7:0]  rom_byte_t;

	// Word address into the shared memory
	typedef logic [`MEM_AW-1:0] mem_addr_t;

	// CPU byte addresses
	typedef logic [`MAIN_AW-1:0] main_addr_t;
	typedef logic [`SND_AW-1:0]  snd_addr_t;

endpackage

/* src/rom_loader.sv */
`timescale 1ns/1ps
`include "druaga_settings.svh"

module rom_loader import druaga_pkg::*; (
	input  logic              clock_48,
	input  logic              rst_n,
	input  logic              ioctl_download,
	input  logic              ioctl_wr,
	input  logic [`DL_AW-1:0] ioctl_addr,
	input  rom_byte_t         ioctl_dout,
	input  logic              status_reset,
	output logic              wr_en,
	output mem_addr_t         wr_addr,
	output logic [1:0]        wr_be,
	output mem_word_t         wr_data,
	output logic              rom_loaded,
	output logic              core_reset
);

	logic              ioctl_wr_last;
	logic              dl_last;
	logic [`DL_AW-2:0] dl_word;
	logic              wr_edge;

	assign dl_word = ioctl_addr[`DL_AW-1:1];
	assign wr_edge = ioctl_download & ioctl_wr & ~ioctl_wr_last;

	always_ff @(posedge clock_48 or negedge rst_n) begin
		if (!rst_n) begin
			ioctl_wr_last <= 1'b0;
			dl_last       <= 1'b0;
			wr_en         <= 1'b0;
			rom_loaded    <= 1'b0;
			core_reset    <= 1'b1;
		end else begin
			ioctl_wr_last <= ioctl_wr;
			dl_last       <= ioctl_download;
			wr_en         <= wr_edge;

			// End of download, sticky until reset
			if (dl_last & ~ioctl_download) begin
				rom_loaded <= 1'b1;
			end

			core_reset <= status_reset | ioctl_download | ~rom_loaded;
		end
	end

	// Byte goes on both lanes, enable picks one
	always_ff @(posedge clock_48) begin
		if (wr_edge) begin
			wr_addr <= mem_addr_t'(dl_word);
			wr_be   <= ioctl_addr[0] ? 2'b10 : 2'b01; // Odd byte is high lane
			wr_data <= {ioctl_dout, ioctl_dout};
		end
	end

endmodule

/* src/rom_fetch_port.sv */
`timescale 1ns/1ps

module rom_fetch_port import druaga_pkg::*; #(
	parameter type addr_type = main_addr_t,
	parameter int  word_base = 0
) (
	input  logic      clock_48,
	input  logic      rst_n,
	input  logic      cpu_rd,
	input  addr_type  cpu_addr,
	output rom_byte_t cpu_data,
	output logic      cpu_valid,
	output logic      rd_req,
	output mem_addr_t rd_addr,
	input  logic      rd_done,
	input  mem_word_t rd_data
);

	logic     pending;
	addr_type req_addr;
	logic     take_req;

	assign take_req = cpu_rd & ~pending; // Pulses while busy are dropped

	// Request drops as soon as the data is back
	assign rd_req  = pending & ~rd_done;
	assign rd_addr = mem_addr_t'(word_base) + mem_addr_t'(req_addr >> 1);

	always_ff @(posedge clock_48 or negedge rst_n) begin
		if (!rst_n) begin
			pending   <= 1'b0;
			cpu_valid <= 1'b0;
		end else begin
			cpu_valid <= rd_done;
			if (rd_done) begin
				pending <= 1'b0;
			end else if (take_req) begin
				pending <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock_48) begin
		if (take_req) begin
			req_addr <= cpu_addr;
		end

		// Lane select from the latched byte address
		if (rd_done) begin
			cpu_data <= req_addr[0] ? rd_data[15:8] : rd_data[7:0];
		end
	end

endmodule

/* src/rom_mem_arbiter.sv */
`timescale 1ns/1ps
`include "druaga_settings.svh"

module rom_mem_arbiter import druaga_pkg::*; (
	input  logic       clock_48,
	input  logic       rst_n,
	input  logic       dl_active,
	input  logic       wr_en,
	input  mem_addr_t  wr_addr,
	input  logic [1:0] wr_be,
	input  mem_word_t  wr_data,
	input  logic       main_req,
	input  mem_addr_t  main_addr,
	output logic       main_done,
	input  logic       snd_req,
	input  mem_addr_t  snd_addr,
	output logic       snd_done,
	output mem_word_t  rd_data
);

	mem_word_t mem [`ROM_WORDS];

	logic      blocked;
	logic      gnt_main;
	logic      gnt_snd;
	logic      gnt_any;
	logic      last_snd; // Last grant went to the sound port
	logic      rd_vld;
	logic      rd_tag;   // Owner of the word in rd_data, 1 is sound
	mem_addr_t rd_addr;

	// Loader owns the memory while it writes or downloads
	assign blocked = wr_en | dl_active;

	// Round robin on contention
	assign gnt_main = ~blocked & main_req & (~snd_req | last_snd);
	assign gnt_snd  = ~blocked & snd_req & (~main_req | ~last_snd);
	assign gnt_any  = gnt_main | gnt_snd;

	assign rd_addr = gnt_snd ? snd_addr : main_addr;

	always_ff @(posedge clock_48 or negedge rst_n) begin
		if (!rst_n) begin
			last_snd <= 1'b0;
			rd_vld   <= 1'b0;
			rd_tag   <= 1'b0;
		end else begin
			rd_vld <= gnt_any;
			if (gnt_any) begin
				rd_tag   <= gnt_snd;
				last_snd <= gnt_snd;
			end
		end
	end

	// Done pulses line up with rd_data
	assign main_done = rd_vld & ~rd_tag;
	assign snd_done  = rd_vld & rd_tag;

	// Byte lane writes
	always_ff @(posedge clock_48) begin
		if (wr_en) begin
			if (wr_be[0]) begin
				mem[wr_addr][7:0] <= wr_data[7:0];
			end
			if (wr_be[1]) begin
				mem[wr_addr][15:8] <= wr_data[15:8];
			end
		end
	end

	// Registered read, one edge after the grant
	always_ff @(posedge clock_48) begin
		if (gnt_any) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

/* src/dip_mapper.sv */
`timescale 1ns/1ps

module dip_mapper import druaga_pkg::*; (
	input  game_model_e model,
	input  logic [31:0] status,
	input  logic [5:0]  p1,     // Fire B, fire A, left, down, right, up
	input  logic [5:0]  p2,
	input  logic        coin,
	input  logic        start1,
	input  logic        start2,
	output rom_byte_t   dsw0,
	output rom_byte_t   dsw1,
	output rom_byte_t   dsw2,
	output rom_byte_t   inp0,
	output rom_byte_t   inp1,
	output rom_byte_t   inp2
);

	logic freeze;
	logic service;
	logic cabinet;

	assign freeze  = status[29];
	assign service = status[30];
	assign cabinet = 1'b0; // Upright only

	assign inp0 = {2'b00, p1};
	assign inp1 = {2'b00, p2};
	assign inp2 = {5'b00000, coin, start2, start1};

	always_comb begin
		case (model)
			druaga_a, druaga_b: begin
				dsw0 = {2'b00, status[9:8], 4'b0000}; // Lives
				dsw1 = {cabinet, 6'b000000, freeze};
				dsw2 = {dsw1[3:0], service, 3'b000};
			end
			mappy: begin
				dsw0 = {freeze, status[6], status[13], 2'b00, status[12:10]};
				dsw1 = {status[18:17], status[16:14], 3'b000}; // Lives, extend
				dsw2 = {2{service, cabinet, 2'b00}};
			end
			digdug2: begin
				dsw0 = {2'b00, status[19], 5'b00000};
				dsw1 = {cabinet, 3'b000, freeze, status[22], status[21:20]};
				dsw2 = {dsw1[3:0], service, 3'b000};
			end
			motos: begin
				dsw0 = {status[27], status[26:25], status[24], status[23], 3'b000};
				dsw1 = {service, cabinet, 6'b000000};
				dsw2 = 8'h00;
			end
			default: begin
				// No switches mapped yet
				dsw0 = 8'h00;
				dsw1 = 8'h00;
				dsw2 = 8'h00;
			end
		endcase
	end

endmodule

/* src/druaga_rom_top.sv */
`timescale 1ns/1ps
`include "druaga_settings.svh"

module druaga_rom_top import druaga_pkg::*; (
	input  logic              clock_48,
	input  logic              rst_n,
	input  logic              ioctl_download,
	input  logic              ioctl_wr,
	input  logic [`DL_AW-1:0] ioctl_addr,
	input  rom_byte_t         ioctl_dout,
	input  logic [31:0]       status,
	input  game_model_e       core_mod,
	input  logic [5:0]        p1,
	input  logic [5:0]        p2,
	input  logic              coin,
	input  logic              start1,
	input  logic              start2,
	input  logic              main_rd,
	input  main_addr_t        main_addr,
	output rom_byte_t         main_data,
	output logic              main_valid,
	input  logic              snd_rd,
	input  snd_addr_t         snd_addr,
	output rom_byte_t         snd_data,
	output logic              snd_valid,
	output logic              rom_loaded,
	output logic              core_reset,
	output logic              led,
	output rom_byte_t         dsw0,
	output rom_byte_t         dsw1,
	output rom_byte_t         dsw2,
	output rom_byte_t         inp0,
	output rom_byte_t         inp1,
	output rom_byte_t         inp2
);

	logic       wr_en;
	mem_addr_t  wr_addr;
	logic [1:0] wr_be;
	mem_word_t  wr_data;
	logic       main_req;
	mem_addr_t  main_word_addr;
	logic       main_done;
	logic       snd_req;
	mem_addr_t  snd_word_addr;
	logic       snd_done;
	mem_word_t  rd_data;

	assign led = ~ioctl_download; // Lit when idle

	rom_loader u_rom_loader (
		.clock_48, .rst_n, .ioctl_download, .ioctl_wr, .ioctl_addr, .ioctl_dout,
		.status_reset (status[0]),
		.wr_en, .wr_addr, .wr_be, .wr_data, .rom_loaded, .core_reset
	);

	rom_mem_arbiter u_rom_mem_arbiter (
		.clock_48, .rst_n,
		.dl_active (ioctl_download),
		.wr_en, .wr_addr, .wr_be, .wr_data,
		.main_req, .main_addr (main_word_addr), .main_done,
		.snd_req, .snd_addr (snd_word_addr), .snd_done,
		.rd_data
	);

	rom_fetch_port #(.addr_type(main_addr_t), .word_base(0)) u_main_port (
		.clock_48, .rst_n,
		.cpu_rd (main_rd), .cpu_addr (main_addr), .cpu_data (main_data), .cpu_valid (main_valid),
		.rd_req (main_req), .rd_addr (main_word_addr), .rd_done (main_done), .rd_data
	);

	// Sound ROM sits above the main CPU region
	rom_fetch_port #(.addr_type(snd_addr_t), .word_base(`SND_WORD_BASE)) u_snd_port (
		.clock_48, .rst_n,
		.cpu_rd (snd_rd), .cpu_addr (snd_addr), .cpu_data (snd_data), .cpu_valid (snd_valid),
		.rd_req (snd_req), .rd_addr (snd_word_addr), .rd_done (snd_done), .rd_data
	);

	dip_mapper u_dip_mapper (
		.model (core_mod),
		.status, .p1, .p2, .coin, .start1, .start2,
		.dsw0, .dsw1, .dsw2, .inp0, .inp1, .inp2
	);

endmodule

/* tb/rom_checker.sv */
`timescale 1ns/1ps
`include "druaga_settings.svh"

module rom_checker import druaga_pkg::*; (
	input logic              clock_48,
	input logic              rst_n,
	input logic              ioctl_download,
	input logic              ioctl_wr,
	input logic [`DL_AW-1:0] ioctl_addr,
	input rom_byte_t         ioctl_dout,
	input logic              main_rd,
	input main_addr_t        main_addr,
	input rom_byte_t         main_data,
	input logic              main_valid,
	input logic              snd_rd,
	input snd_addr_t         snd_addr,
	input rom_byte_t         snd_data,
	input logic              snd_valid,
	input rom_byte_t         dsw0,
	input rom_byte_t         dsw1,
	input rom_byte_t         dsw2,
	input rom_byte_t         inp0,
	input rom_byte_t         inp1,
	input rom_byte_t         inp2
);

	rom_byte_t shadow [1 << `DL_AW]; // Every byte the download wrote
	logic      wr_last;
	logic      main_busy;
	logic      snd_busy;
	int        main_byte;
	int        snd_byte;
	int        main_start;
	int        snd_start;
	int        cycle = 0;
	int        checks = 0;
	int        mismatches = 0;
	int        other_fails = 0;

	function automatic int failures();
		return mismatches + other_fails;
	endfunction

	task automatic note_failure(input string why);
		other_fails++;
		$display("%0t ns: %s", $time, why);
	endtask

	task automatic compare(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (exp !== act) begin
			mismatches++;
			$display("mismatch at %0t ns: %s expected 8'h%02h got 8'h%02h", $time, name, exp, act);
		end
	endtask

	task automatic check_dip(input logic [23:0] exp_dsw, input logic [23:0] exp_inp);
		compare("dsw0", exp_dsw[23:16], dsw0);
		compare("dsw1", exp_dsw[15:8], dsw1);
		compare("dsw2", exp_dsw[7:0], dsw2);
		compare("inp0", exp_inp[23:16], inp0);
		compare("inp1", exp_inp[15:8], inp1);
		compare("inp2", exp_inp[7:0], inp2);
	endtask

	task automatic report_counts();
		$display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, other_fails);
	endtask

	always @(posedge clock_48 or negedge rst_n) begin
		if (!rst_n) begin
			wr_last   = 1'b0;
			main_busy = 1'b0;
			snd_busy  = 1'b0;
		end else begin
			cycle++;
			if (ioctl_download && ioctl_wr && !wr_last) begin
				shadow[ioctl_addr] = ioctl_dout;
			end
			wr_last = ioctl_wr;

			if (main_valid) begin
				if (!main_busy) begin
					note_failure("main_valid pulsed with no main request outstanding");
				end else begin
					compare("main_data", shadow[main_byte], main_data);
					if (cycle - main_start < 3) begin
						note_failure("main_valid came less than 3 cycles after main_rd");
					end
				end
				main_busy = 1'b0;
			end
			if (main_rd && !main_busy) begin
				main_busy  = 1'b1;
				main_byte  = int'(main_addr);
				main_start = cycle;
			end

			if (snd_valid) begin
				if (!snd_busy) begin
					note_failure("snd_valid pulsed with no sound request outstanding");
				end else begin
					compare("snd_data", shadow[snd_byte], snd_data);
					if (cycle - snd_start < 3) begin
						note_failure("snd_valid came less than 3 cycles after snd_rd");
					end
				end
				snd_busy = 1'b0;
			end
			if (snd_rd && !snd_busy) begin
				snd_busy  = 1'b1;
				snd_byte  = 16'h4000 + int'(snd_addr); // Sound ROM region of the download
				snd_start = cycle;
			end
		end
	end

endmodule

/* tb/tb_druaga_rom_top.sv */
`timescale 1ns/1ps
`include "druaga_settings.svh"

module tb_druaga_rom_top import druaga_pkg::*; ();

	logic              clock_48;
	logic              rst_n;
	logic              ioctl_download;
	logic              ioctl_wr;
	logic [`DL_AW-1:0] ioctl_addr;
	rom_byte_t         ioctl_dout;
	logic [31:0]       status;
	game_model_e       core_mod;
	logic [5:0]        p1;
	logic [5:0]        p2;
	logic              coin;
	logic              start1;
	logic              start2;
	logic              main_rd;
	main_addr_t        main_addr;
	rom_byte_t         main_data;
	logic              main_valid;
	logic              snd_rd;
	snd_addr_t         snd_addr;
	rom_byte_t         snd_data;
	logic              snd_valid;
	logic              rom_loaded;
	logic              core_reset;
	logic              led;
	rom_byte_t         dsw0;
	rom_byte_t         dsw1;
	rom_byte_t         dsw2;
	rom_byte_t         inp0;
	rom_byte_t         inp1;
	rom_byte_t         inp2;

	// Status patterns with {p1, p2, coin, start1, start2} and expected bytes
	logic [31:0] stat_tab [3] = '{32'h7fff_fffe, 32'h0000_0000, 32'h2090_4500};
	logic [14:0] ctl_tab  [3] = '{{6'h2a, 6'h15, 3'b101}, {6'h3f, 6'h00, 3'b010},
		{6'h01, 6'h20, 3'b111}};
	logic [23:0] inp_tab  [3] = '{24'h2a_15_06, 24'h3f_00_01, 24'h01_20_07};
	logic [23:0] dsw_tab  [3][8] = '{
		'{24'h30_01_18, 24'h30_01_18, 24'he7_f8_88, 24'h20_0f_f8, 24'hf8_80_00, 0, 0, 0},
		'{0, 0, 0, 0, 0, 0, 0, 0},
		'{24'h10_01_10, 24'h10_01_10, 24'h81_08_00, 24'h00_09_90, 24'h08_00_00, 0, 0, 0}};

	druaga_rom_top u_druaga_rom_top (.*);
	rom_checker u_rom_checker (.*);

	initial begin
		clock_48 = 1'b0;
		forever #4 clock_48 = ~clock_48;
	end

	task automatic write_byte(input int addr, input int data);
		@(negedge clock_48);
		ioctl_addr = `DL_AW'(addr);
		ioctl_dout = 8'(data);
		ioctl_wr   = 1'b1;
		@(negedge clock_48);
		ioctl_wr = 1'b0;
	endtask

	// One read pulse, then wait for the matching valid
	task automatic issue_fetch(input bit snd, input int addr);
		int n;
		@(negedge clock_48);
		if (snd) begin
			snd_rd   = 1'b1;
			snd_addr = snd_addr_t'(addr);
		end else begin
			main_rd   = 1'b1;
			main_addr = main_addr_t'(addr);
		end
		@(negedge clock_48);
		main_rd = snd ? main_rd : 1'b0;
		snd_rd  = snd ? 1'b0 : snd_rd;
		n = 0;
		while (!(snd ? snd_valid : main_valid) && n < 20) begin
			@(negedge clock_48);
			n++;
		end
		if (!(snd ? snd_valid : main_valid)) begin
			u_rom_checker.note_failure($sformatf("%s fetch of 0x%0h got no valid in 20 cycles",
				snd ? "sound" : "main", addr));
		end
	endtask

	// Read strobe on every cycle until enough fetches came back
	task automatic stream_fetches(input bit snd, input int count);
		int done;
		int idle;
		done = 0;
		idle = 0;
		while (done < count && idle < 20) begin
			@(negedge clock_48);
			if (snd) begin
				snd_rd   = 1'b1;
				snd_addr = snd_addr_t'($urandom_range(8191));
			end else begin
				main_rd   = 1'b1;
				main_addr = main_addr_t'($urandom_range(16383));
			end
			if (snd ? snd_valid : main_valid) begin
				done++;
				idle = 0;
			end else begin
				idle++;
			end
		end
		if (snd) begin
			snd_rd = 1'b0;
		end else begin
			main_rd = 1'b0;
		end
		if (done < count) begin
			u_rom_checker.note_failure($sformatf("%s port stalled after %0d of %0d fetches",
				snd ? "sound" : "main", done, count));
		end
	endtask

	initial begin
		int n;
		int a;
		int new_addr[$];
		void'($urandom(32'hc958_b095));
		rst_n = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		status = '0;
		core_mod = druaga_a;
		{p1, p2, coin, start1, start2} = '0;
		{main_rd, snd_rd} = 2'b00;
		main_addr = '0;
		snd_addr = '0;
		repeat (3) @(negedge clock_48);
		rst_n = 1'b1;
		@(negedge clock_48);

		u_rom_checker.compare("core_reset", 8'd1, {7'd0, core_reset});
		u_rom_checker.compare("rom_loaded", 8'd0, {7'd0, rom_loaded});
		u_rom_checker.compare("led", 8'd1, {7'd0, led});

		// Requests made now must wait out the whole download
		ioctl_download = 1'b1;
		{main_rd, snd_rd} = 2'b11;
		main_addr = 14'h0123;
		snd_addr = 13'h0456;
		@(negedge clock_48);
		{main_rd, snd_rd} = 2'b00;
		n = 0;
		repeat (20) begin
			@(negedge clock_48);
			n += int'(main_valid | snd_valid);
		end
		if (n != 0) u_rom_checker.note_failure("fetch completed while the download was active");
		u_rom_checker.compare("led", 8'd0, {7'd0, led});

		for (a = 0; a < 24576; a++) write_byte(a, $urandom);
		@(negedge clock_48);
		u_rom_checker.compare("rom_loaded", 8'd0, {7'd0, rom_loaded});
		u_rom_checker.compare("core_reset", 8'd1, {7'd0, core_reset});
		ioctl_download = 1'b0;
		@(negedge clock_48);
		u_rom_checker.compare("rom_loaded", 8'd1, {7'd0, rom_loaded});
		n = 0;
		while ((!rom_loaded || core_reset) && n < 10) begin
			@(negedge clock_48);
			n++;
		end
		if (!rom_loaded || core_reset) begin
			u_rom_checker.note_failure("game stayed in reset after download");
		end
		n = 0;
		while ((u_rom_checker.main_busy || u_rom_checker.snd_busy) && n < 20) begin
			@(negedge clock_48);
			n++;
		end
		if (u_rom_checker.main_busy || u_rom_checker.snd_busy) begin
			u_rom_checker.note_failure("fetches held over the download never finished");
		end

		repeat (150) begin
			issue_fetch(1'b0, $urandom_range(16383));
			issue_fetch(1'b1, $urandom_range(8191));
		end

		// Both ports strobing every cycle under contention
		fork
			stream_fetches(1'b0, 100);
			stream_fetches(1'b1, 100);
		join

		for (int k = 0; k < 3; k++) begin
			for (int m = 0; m < 8; m++) begin
				@(negedge clock_48);
				status = stat_tab[k];
				core_mod = game_model_e'(m);
				{p1, p2, coin, start1, start2} = ctl_tab[k];
				#1 u_rom_checker.check_dip(dsw_tab[k][m], inp_tab[k]);
			end
		end

		@(negedge clock_48);
		status = 32'h1;
		n = 0;
		while (!core_reset && n < 5) begin
			@(negedge clock_48);
			n++;
		end
		if (!core_reset) u_rom_checker.note_failure("status bit 0 did not raise core_reset");
		status = '0;

		ioctl_download = 1'b1;
		repeat (64) begin
			a = $urandom_range(24575);
			new_addr.push_back(a);
			write_byte(a, $urandom);
		end
		@(negedge clock_48);
		u_rom_checker.compare("core_reset", 8'd1, {7'd0, core_reset});
		u_rom_checker.compare("rom_loaded", 8'd1, {7'd0, rom_loaded});
		ioctl_download = 1'b0;
		n = 0;
		while (core_reset && n < 10) begin
			@(negedge clock_48);
			n++;
		end
		if (core_reset) u_rom_checker.note_failure("core_reset stuck after second download");
		foreach (new_addr[i]) begin
			if (new_addr[i] < 16384) issue_fetch(1'b0, new_addr[i]);
			else issue_fetch(1'b1, new_addr[i] - 16384);
		end

		repeat (2) @(negedge clock_48);
		u_rom_checker.report_counts();
		if (u_rom_checker.failures() == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* src.f */
+incdir+src
src/druaga_pkg.sv
src/rom_loader.sv
src/rom_fetch_port.sv
src/rom_mem_arbiter.sv
src/dip_mapper.sv
src/druaga_rom_top.sv
tb/rom_checker.sv
tb/tb_druaga_rom_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_druaga_rom_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
PASS_MSG  ?= Simulation passed

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
